// ==== src/axil_sram_macros.svh ====
`ifndef AXIL_SRAM_MACROS_SVH
`define AXIL_SRAM_MACROS_SVH

// byte address width on the AXI-Lite side
`define AXIL_ADDR_WIDTH 10

// data width shared by both sides of the bridge
`define AXIL_DATA_WIDTH 32

// word address width of the SRAM
// this is the byte address width less the byte-lane bits
`define SRAM_DEPTH_LOG2 8

// number of byte lanes in one data word
`define AXIL_STRB_WIDTH (`AXIL_DATA_WIDTH / 8)

`endif

// ==== src/axil_pkg.sv ====
`default_nettype none

`include "axil_sram_macros.svh"

package axil_pkg;

  typedef logic [`AXIL_ADDR_WIDTH-1:0] axil_addr_t;
  typedef logic [`AXIL_DATA_WIDTH-1:0] axil_data_t;
  typedef logic [`AXIL_STRB_WIDTH-1:0] axil_strb_t;

  // response codes as carried on rresp and bresp
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axil_resp_t;

  // low address bits that select a byte within a word
  localparam int AXIL_LSB = $clog2(`AXIL_STRB_WIDTH);

endpackage

`default_nettype wire

// ==== src/sram_pkg.sv ====
`default_nettype none

`include "axil_sram_macros.svh"

package sram_pkg;

  typedef logic [`SRAM_DEPTH_LOG2-1:0] sram_addr_t;
  typedef logic [`AXIL_DATA_WIDTH-1:0] sram_data_t;
  typedef logic [`AXIL_STRB_WIDTH-1:0] sram_be_t;

  // number of words the word address can reach
  localparam int SRAM_DEPTH = 2 ** `SRAM_DEPTH_LOG2;

  // bits dropped when a byte address becomes a word address
  localparam int SRAM_ADDR_SHIFT = `AXIL_ADDR_WIDTH - `SRAM_DEPTH_LOG2;

endpackage

`default_nettype wire

// ==== src/axil_sram_if_rd.sv ====
`timescale 1ns/1ps
`default_nettype none

// the SRAM has no way to report errors, so every read returns OKAY
module axil_sram_if_rd (
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic                   arvalid,
  input  axil_pkg::axil_addr_t   araddr,
  output logic                   arready,

  output logic                   rvalid,
  output axil_pkg::axil_data_t   rdata,
  output axil_pkg::axil_resp_t   rresp,
  input  logic                   rready,

  output logic                   rd_cmd_valid,
  input  logic                   rd_cmd_ready,
  output sram_pkg::sram_addr_t   rd_cmd_addr,

  input  logic                   rd_resp_valid,
  output logic                   rd_resp_ready,
  input  sram_pkg::sram_data_t   rd_resp_data
);
  import axil_pkg::*;

  logic unused;

  // the byte address becomes a word address by dropping the lane bits
  assign rd_cmd_valid  = arvalid;
  assign arready       = rd_cmd_ready;
  assign rd_cmd_addr   = araddr[$bits(araddr)-1:AXIL_LSB];

  assign rvalid        = rd_resp_valid;
  assign rdata         = rd_resp_data;
  assign rd_resp_ready = rready;
  assign rresp         = OKAY;

  // clk and rst_n only keep the port list in step with the write adapter
  assign unused = &{1'b0, clk, rst_n, araddr[AXIL_LSB-1:0]};

endmodule

`default_nettype wire

// ==== src/axil_sram_if_wr.sv ====
`timescale 1ns/1ps
`default_nettype none

// AW and W are captured separately, in either order, and then issued to the
// SRAM as one write command
module axil_sram_if_wr (
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic                   awvalid,
  input  axil_pkg::axil_addr_t   awaddr,
  output logic                   awready,

  input  logic                   wvalid,
  input  axil_pkg::axil_data_t   wdata,
  input  axil_pkg::axil_strb_t   wstrb,
  output logic                   wready,

  output logic                   bvalid,
  output axil_pkg::axil_resp_t   bresp,
  input  logic                   bready,

  output logic                   wr_cmd_valid,
  input  logic                   wr_cmd_ready,
  output sram_pkg::sram_addr_t   wr_cmd_addr,
  output sram_pkg::sram_data_t   wr_cmd_data,
  output sram_pkg::sram_be_t     wr_cmd_be
);
  import axil_pkg::*;
  import sram_pkg::*;

  logic       aw_have;
  logic       w_have;
  logic       cmd_valid_q;
  logic       bvalid_q;
  sram_addr_t addr_q;
  sram_data_t data_q;
  sram_be_t   be_q;
  logic       aw_fire;
  logic       w_fire;
  logic       cmd_fire;
  logic       b_fire;
  logic       unused;

  // each have-flag stays set until B completes, which also refuses new
  // beats while the response is back-pressured
  assign awready  = !aw_have;
  assign wready   = !w_have;

  assign aw_fire  = awvalid && awready;
  assign w_fire   = wvalid && wready;
  assign cmd_fire = cmd_valid_q && wr_cmd_ready;
  assign b_fire   = bvalid_q && bready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      aw_have     <= 1'b0;
      w_have      <= 1'b0;
      cmd_valid_q <= 1'b0;
      bvalid_q    <= 1'b0;
    end else begin
      if (aw_fire) begin
        aw_have <= 1'b1;
      end
      if (w_fire) begin
        w_have <= 1'b1;
      end

      // issue once both halves are held and nothing is already in flight
      if (aw_have && w_have && !cmd_valid_q && !bvalid_q) begin
        cmd_valid_q <= 1'b1;
      end else if (cmd_fire) begin
        cmd_valid_q <= 1'b0;
      end

      if (cmd_fire) begin
        bvalid_q <= 1'b1;
      end else if (b_fire) begin
        bvalid_q <= 1'b0;
        aw_have  <= 1'b0;
        w_have   <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      addr_q <= awaddr[$bits(awaddr)-1:AXIL_LSB];
    end
    if (w_fire) begin
      data_q <= wdata;
      be_q   <= wstrb;
    end
  end

  assign wr_cmd_valid = cmd_valid_q;
  assign wr_cmd_addr  = addr_q;
  assign wr_cmd_data  = data_q;
  assign wr_cmd_be    = be_q;

  assign bvalid = bvalid_q;
  assign bresp  = OKAY;

  // the lane bits of awaddr carry no meaning for a word-wide SRAM
  assign unused = &{1'b0, awaddr[AXIL_LSB-1:0]};

endmodule

`default_nettype wire

// ==== src/sram_port_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

// shares the single SRAM port between the read and write adapters
module sram_port_arbiter (
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic                   rd_cmd_valid,
  output logic                   rd_cmd_ready,
  input  sram_pkg::sram_addr_t   rd_cmd_addr,

  input  logic                   wr_cmd_valid,
  output logic                   wr_cmd_ready,
  input  sram_pkg::sram_addr_t   wr_cmd_addr,
  input  sram_pkg::sram_data_t   wr_cmd_data,
  input  sram_pkg::sram_be_t     wr_cmd_be,

  output logic                   cmd_valid,
  input  logic                   cmd_ready,
  output logic                   cmd_write,
  output sram_pkg::sram_addr_t   cmd_addr,
  output sram_pkg::sram_data_t   cmd_data,
  output sram_pkg::sram_be_t     cmd_be
);
  // last_wr remembers which side was granted most recently
  logic last_wr;
  // hold is set while a granted command is still waiting for cmd_ready
  logic hold;
  logic grant_wr;

  always_comb begin
    if (hold) begin
      grant_wr = last_wr;
    end else if (rd_cmd_valid && wr_cmd_valid) begin
      grant_wr = !last_wr;
    end else begin
      grant_wr = wr_cmd_valid;
    end
  end

  assign cmd_valid    = grant_wr ? wr_cmd_valid : rd_cmd_valid;
  assign cmd_write    = grant_wr;
  assign cmd_addr     = grant_wr ? wr_cmd_addr : rd_cmd_addr;
  assign cmd_data     = wr_cmd_data;
  // byte enables mean nothing on a read, keep them quiet
  assign cmd_be       = grant_wr ? wr_cmd_be : '0;

  assign rd_cmd_ready = cmd_ready && !grant_wr;
  assign wr_cmd_ready = cmd_ready && grant_wr;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_wr <= 1'b0;
      hold    <= 1'b0;
    end else if (cmd_valid) begin
      last_wr <= grant_wr;
      hold    <= !cmd_ready;
    end else begin
      hold <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== src/sram_store.sv ====
`timescale 1ns/1ps
`default_nettype none

// single-port word memory with byte writes and a registered read port
module sram_store (
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic                   cmd_valid,
  output logic                   cmd_ready,
  input  logic                   cmd_write,
  input  sram_pkg::sram_addr_t   cmd_addr,
  input  sram_pkg::sram_data_t   cmd_data,
  input  sram_pkg::sram_be_t     cmd_be,

  output logic                   rd_resp_valid,
  input  logic                   rd_resp_ready,
  output sram_pkg::sram_data_t   rd_resp_data
);
  import sram_pkg::*;

  sram_data_t mem [SRAM_DEPTH];
  sram_data_t rdata_q;
  logic       pending;
  logic       cmd_fire;

  // a read response waiting to be taken blocks the port
  assign cmd_ready = !pending;
  assign cmd_fire  = cmd_valid && cmd_ready;

  always_ff @(posedge clk) begin
    if (cmd_fire && cmd_write) begin
      for (int i = 0; i < $bits(sram_be_t); i++) begin
        if (cmd_be[i]) begin
          mem[cmd_addr][8*i +: 8] <= cmd_data[8*i +: 8];
        end
      end
    end
  end

  // the read word is captured at acceptance and held until it is taken
  always_ff @(posedge clk) begin
    if (cmd_fire && !cmd_write) begin
      rdata_q <= mem[cmd_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending <= 1'b0;
    end else if (cmd_fire && !cmd_write) begin
      pending <= 1'b1;
    end else if (pending && rd_resp_ready) begin
      pending <= 1'b0;
    end
  end

  assign rd_resp_valid = pending;
  assign rd_resp_data  = rdata_q;

endmodule

`default_nettype wire

// ==== src/axil_sram_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// AXI-Lite subordinate backed by on-chip SRAM
module axil_sram_top (
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic                   arvalid,
  input  axil_pkg::axil_addr_t   araddr,
  output logic                   arready,

  output logic                   rvalid,
  output axil_pkg::axil_data_t   rdata,
  output axil_pkg::axil_resp_t   rresp,
  input  logic                   rready,

  input  logic                   awvalid,
  input  axil_pkg::axil_addr_t   awaddr,
  output logic                   awready,

  input  logic                   wvalid,
  input  axil_pkg::axil_data_t   wdata,
  input  axil_pkg::axil_strb_t   wstrb,
  output logic                   wready,

  output logic                   bvalid,
  output axil_pkg::axil_resp_t   bresp,
  input  logic                   bready
);
  import sram_pkg::*;

  logic       rd_cmd_valid;
  logic       rd_cmd_ready;
  sram_addr_t rd_cmd_addr;
  logic       wr_cmd_valid;
  logic       wr_cmd_ready;
  sram_addr_t wr_cmd_addr;
  sram_data_t wr_cmd_data;
  sram_be_t   wr_cmd_be;
  logic       cmd_valid;
  logic       cmd_ready;
  logic       cmd_write;
  sram_addr_t cmd_addr;
  sram_data_t cmd_data;
  sram_be_t   cmd_be;
  logic       rd_resp_valid;
  logic       rd_resp_ready;
  sram_data_t rd_resp_data;

  axil_sram_if_rd u_if_rd (
    .clk, .rst_n,
    .arvalid, .araddr, .arready,
    .rvalid, .rdata, .rresp, .rready,
    .rd_cmd_valid, .rd_cmd_ready, .rd_cmd_addr,
    .rd_resp_valid, .rd_resp_ready, .rd_resp_data
  );

  axil_sram_if_wr u_if_wr (
    .clk, .rst_n,
    .awvalid, .awaddr, .awready,
    .wvalid, .wdata, .wstrb, .wready,
    .bvalid, .bresp, .bready,
    .wr_cmd_valid, .wr_cmd_ready, .wr_cmd_addr, .wr_cmd_data, .wr_cmd_be
  );

  // reads and writes take turns on the one SRAM port
  sram_port_arbiter u_arbiter (
    .clk, .rst_n,
    .rd_cmd_valid, .rd_cmd_ready, .rd_cmd_addr,
    .wr_cmd_valid, .wr_cmd_ready, .wr_cmd_addr, .wr_cmd_data, .wr_cmd_be,
    .cmd_valid, .cmd_ready, .cmd_write, .cmd_addr, .cmd_data, .cmd_be
  );

  sram_store u_store (
    .clk, .rst_n,
    .cmd_valid, .cmd_ready, .cmd_write, .cmd_addr, .cmd_data, .cmd_be,
    .rd_resp_valid, .rd_resp_ready, .rd_resp_data
  );

endmodule

`default_nettype wire

// ==== testbench/axil_sram_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

// handshake rules on the external AXI-Lite channels of axil_sram_top
module axil_sram_properties (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 arvalid,
  input logic                 arready,
  input axil_pkg::axil_addr_t araddr,
  input logic                 rvalid,
  input logic                 rready,
  input axil_pkg::axil_data_t rdata,
  input axil_pkg::axil_resp_t rresp,
  input logic                 bvalid,
  input logic                 bready,
  input axil_pkg::axil_resp_t bresp
);
  import axil_pkg::*;

  // a stalled AR keeps its address until it is taken
  ar_held: assert property (@(posedge clk) disable iff (!rst_n)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else $error("AR valid dropped or address changed while stalled");

  r_held: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else $error("R valid dropped or payload changed while stalled");

  b_held: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else $error("B valid dropped or response changed while stalled");

  // the SRAM never reports an error
  r_okay: assert property (@(posedge clk) disable iff (!rst_n) rvalid |-> rresp == OKAY)
    else $error("R beat with a response other than OKAY");

  b_okay: assert property (@(posedge clk) disable iff (!rst_n) bvalid |-> bresp == OKAY)
    else $error("B beat with a response other than OKAY");

endmodule

bind axil_sram_top axil_sram_properties u_props (.*);

`default_nettype wire

// ==== testbench/axil_sram_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module axil_sram_tb;
  import axil_pkg::*;
  import sram_pkg::*;

  // 32 + 32 + 32 + 12 + 40 + 48 transactions over the six tests
  localparam int TOTAL_TXNS     = 196;
  localparam int TIMEOUT_CYCLES = TOTAL_TXNS * 40;

  // mode 0 sends AW first, mode 1 sends W first, mode 2 sends both together
  typedef struct {
    axil_addr_t addr;
    axil_data_t data;
    axil_strb_t strb;
    int         mode;
  } wr_req_t;

  logic       clk;
  logic       rst_n;
  logic       arvalid, arready, rvalid, rready;
  logic       awvalid, awready, wvalid, wready, bvalid, bready;
  axil_addr_t araddr, awaddr;
  axil_data_t rdata, wdata;
  axil_strb_t wstrb;
  axil_resp_t rresp, bresp;

  // reference memory, with a mask of the bytes that have been written
  axil_data_t model [SRAM_DEPTH];
  axil_strb_t known [SRAM_DEPTH];

  axil_addr_t ar_todo [$];
  axil_data_t r_exp [$];
  axil_strb_t r_mask [$];
  wr_req_t    wr_todo [$];
  wr_req_t    wr_cur;
  sram_addr_t used [$];
  logic       wr_busy, aw_done, w_done;
  logic       backpressure, gaps;
  logic       ar_fire, r_fire, aw_fire, w_fire, b_fire;
  axil_data_t r_seen_data;
  axil_resp_t r_seen_resp, b_seen_resp;
  int         b_owed;
  int         errors, tests_ok, tests_bad, cycles;
  logic [31:0] rng;

  axil_sram_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_random();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic logic coin();
    return (next_random() & 32'd1) != 0;
  endfunction

  function automatic axil_data_t lane_mask(input axil_strb_t m);
    axil_data_t b;
    for (int i = 0; i < $bits(axil_strb_t); i++) begin
      b[8*i +: 8] = {8{m[i]}};
    end
    return b;
  endfunction

  task automatic check_data(input string name, input axil_data_t expected,
                            input axil_data_t actual);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s expected %08h got %08h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_resp(input string name, input axil_resp_t expected,
                            input axil_resp_t actual);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s expected %s got %b", $time, name, expected.name(),
               actual);
      errors++;
    end
  endtask

  task automatic queue_write(input sram_addr_t word, input axil_strb_t strb, input int mode);
    wr_req_t req;
    req.addr = axil_addr_t'(word) << AXIL_LSB;
    req.data = next_random();
    req.strb = strb;
    req.mode = mode;
    wr_todo.push_back(req);
  endtask

  task automatic queue_read(input sram_addr_t word, input int lane);
    ar_todo.push_back((axil_addr_t'(word) << AXIL_LSB) | axil_addr_t'(lane));
  endtask

  // one clock of the bus driver, working from the falling edge
  task automatic run_cycle();
    sram_addr_t word;
    axil_data_t m;
    @(negedge clk);
    // retire what transferred at the last rising edge
    if (ar_fire) begin
      arvalid = 1'b0;
    end
    if (aw_fire) begin
      awvalid = 1'b0;
      aw_done = 1'b1;
    end
    if (w_fire) begin
      wvalid = 1'b0;
      w_done = 1'b1;
    end
    if (wr_busy && aw_done && w_done) begin
      wr_busy = 1'b0;
      b_owed++;
    end
    if (r_fire) begin
      if (r_exp.size() == 0) begin
        $display("error at %0t: an R beat arrived with no read outstanding", $time);
        errors++;
      end else begin
        m = lane_mask(r_mask.pop_front());
        check_resp("rresp", OKAY, r_seen_resp);
        check_data("rdata", r_exp.pop_front() & m, r_seen_data & m);
      end
    end
    if (b_fire) begin
      if (b_owed == 0) begin
        $display("error at %0t: a B beat arrived with no write outstanding", $time);
        errors++;
      end else begin
        b_owed--;
        check_resp("bresp", OKAY, b_seen_resp);
      end
    end

    if (!arvalid && ar_todo.size() > 0 && (!gaps || coin())) begin
      araddr = ar_todo.pop_front();
      word = sram_addr_t'(araddr >> AXIL_LSB);
      r_exp.push_back(model[word]);
      r_mask.push_back(known[word]);
      arvalid = 1'b1;
    end

    if (!wr_busy && wr_todo.size() > 0 && (!gaps || coin())) begin
      wr_cur = wr_todo.pop_front();
      word = sram_addr_t'(wr_cur.addr >> AXIL_LSB);
      for (int i = 0; i < $bits(axil_strb_t); i++) begin
        if (wr_cur.strb[i]) begin
          model[word][8*i +: 8] = wr_cur.data[8*i +: 8];
          known[word][i] = 1'b1;
        end
      end
      awaddr  = wr_cur.addr;
      wdata   = wr_cur.data;
      wstrb   = wr_cur.strb;
      aw_done = 1'b0;
      w_done  = 1'b0;
      wr_busy = 1'b1;
      awvalid = (wr_cur.mode != 1);
      wvalid  = (wr_cur.mode != 0);
    end else if (wr_busy) begin
      // the second half follows once the first has been taken
      if (aw_done && !w_done) begin
        wvalid = 1'b1;
      end
      if (w_done && !aw_done) begin
        awvalid = 1'b1;
      end
    end

    rready = !backpressure || coin();
    bready = !backpressure || coin();

    // nothing changes between here and the next rising edge
    #1;
    ar_fire     = arvalid && arready;
    r_fire      = rvalid && rready;
    aw_fire     = awvalid && awready;
    w_fire      = wvalid && wready;
    b_fire      = bvalid && bready;
    r_seen_data = rdata;
    r_seen_resp = rresp;
    b_seen_resp = bresp;
  endtask

  function automatic logic idle();
    return ar_todo.size() == 0 && !arvalid && r_exp.size() == 0 &&
           wr_todo.size() == 0 && !wr_busy && b_owed == 0;
  endfunction

  task automatic run_until_idle();
    while (!idle()) begin
      run_cycle();
    end
    // a repeated beat would show up in these extra cycles
    repeat (4) run_cycle();
  endtask

  task automatic finish_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: FAILED with %0d errors", name, errors - errors_before);
    end
  endtask

  initial begin
    int         e;
    sram_addr_t batch [$];
    rng = 32'd45948;
    errors = 0;
    tests_ok = 0;
    tests_bad = 0;
    b_owed = 0;
    rst_n = 1'b0;
    arvalid = 1'b0;
    araddr = '0;
    rready = 1'b0;
    awvalid = 1'b0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    bready = 1'b0;
    {wr_busy, aw_done, w_done, backpressure, gaps} = '0;
    {ar_fire, r_fire, aw_fire, w_fire, b_fire} = '0;
    for (int i = 0; i < SRAM_DEPTH; i++) begin
      known[i] = '0;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    e = errors;
    for (int i = 0; i < 16; i++) begin
      used.push_back(sram_addr_t'(next_random() % (SRAM_DEPTH / 2)));
      queue_write(used[i], '1, i % 3);
    end
    run_until_idle();
    foreach (used[i]) queue_read(used[i], 0);
    run_until_idle();
    finish_test("write then read back", e);

    e = errors;
    foreach (used[i]) queue_write(used[i], axil_strb_t'(next_random()), i % 3);
    run_until_idle();
    foreach (used[i]) queue_read(used[i], 0);
    run_until_idle();
    finish_test("byte strobes", e);

    e = errors;
    foreach (used[i]) begin
      queue_read(used[i], 0);
      queue_read(used[i], int'(next_random() % 3) + 1);
    end
    run_until_idle();
    finish_test("byte-lane bits ignored", e);

    e = errors;
    for (int i = 0; i < 6; i++) begin
      queue_write(used[i], '1, i % 3);
      run_until_idle();
      queue_read(used[i], 0);
      run_until_idle();
    end
    finish_test("channel order", e);

    e = errors;
    backpressure = 1'b1;
    for (int i = 0; i < 20; i++) begin
      batch.push_back(sram_addr_t'(next_random() % (SRAM_DEPTH / 2)));
      queue_write(batch[i], axil_strb_t'(next_random()), int'(next_random() % 3));
    end
    run_until_idle();
    foreach (batch[i]) queue_read(batch[i], 0);
    run_until_idle();
    finish_test("back-pressure", e);

    // writes go to the upper half while reads stay in the lower half
    e = errors;
    gaps = 1'b1;
    for (int i = 0; i < 24; i++) begin
      queue_write(sram_addr_t'(SRAM_DEPTH / 2 + next_random() % (SRAM_DEPTH / 2)),
                  axil_strb_t'(next_random()), int'(next_random() % 3));
      queue_read(used[i % 16], 0);
    end
    run_until_idle();
    gaps = 1'b0;
    backpressure = 1'b0;
    finish_test("concurrent traffic", e);

    $display("tests: %0d ok, %0d failed, %0d errors", tests_ok, tests_bad, errors);
    if (errors == 0 && tests_bad == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+src
src/axil_pkg.sv
src/sram_pkg.sv
src/axil_sram_if_rd.sv
src/axil_sram_if_wr.sv
src/sram_port_arbiter.sv
src/sram_store.sv
src/axil_sram_top.sv
testbench/axil_sram_properties.sv
testbench/axil_sram_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= axil_sram_tb
RTL_TOP    ?= axil_sram_top
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)

# the log decides the result, an aborted run has no pass line and counts as a failure
run: build
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then echo "simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
